// ==== design/uart_cfg_pkg.sv ====
package uart_cfg_pkg;

   // ----------------------------------------------------------
   // bit timing
   // ----------------------------------------------------------

   localparam int CLKS_PER_TICK = 4;   // kept small so that simulation runs fast.
   localparam int OVERSAMPLE    = 16;  // ticks in one bit time.
   localparam int HALF_BIT      = 8;   // ticks from the start edge to mid start bit.

   // ----------------------------------------------------------
   // frame and buffering
   // ----------------------------------------------------------

   localparam int DATA_BITS  = 8;
   localparam int FIFO_DEPTH = 8;

   // ----------------------------------------------------------
   // counter widths derived from the values above
   // ----------------------------------------------------------

   localparam int DIV_W      = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
   localparam int TICK_CNT_W = $clog2(OVERSAMPLE);
   localparam int BIT_CNT_W  = $clog2(DATA_BITS);

endpackage

// ==== design/uart_types_pkg.sv ====
package uart_types_pkg;

   // ----------------------------------------------------------
   // payload types shared by the datapath
   // ----------------------------------------------------------

   // one data byte, as queued for sending and as received.
   typedef logic [uart_cfg_pkg::DATA_BITS-1:0] uart_byte_t;

   // a received frame with its framing status.
   typedef struct packed {
      uart_byte_t data;       // bits in arrival order, first bit at the lsb.
      logic       frame_err;  // set when the stop bit sampled low.
   } rx_frame_t;

endpackage

// ==== design/uart_baud_gen.sv ====
`timescale 1ns/1ps

module uart_baud_gen (
   input  logic clk_i,
   input  logic rst_i,
   output logic tick_o
);

   typedef logic [uart_cfg_pkg::DIV_W-1:0] div_cnt_t;

   div_cnt_t div_cnt;
   logic     wrap;

   assign wrap   = (div_cnt == div_cnt_t'(uart_cfg_pkg::CLKS_PER_TICK - 1));
   assign tick_o = wrap;  // one clock wide, once per divider period.

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         div_cnt <= '0;
      end else if (wrap) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   tick_period_a: assert property (
      @(posedge clk_i) disable iff (!rst_i)
      tick_o |=> !tick_o [*(uart_cfg_pkg::CLKS_PER_TICK - 1)] ##1 tick_o
   );

endmodule

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
   input  logic                      clk_i,
   input  logic                      rst_i,
   input  logic                      tick_i,
   input  logic                      rx_i,
   input  logic                      rx_en_i,
   output uart_types_pkg::rx_frame_t frame_o,
   output logic                      done_o
);

   typedef enum logic [1:0] {
      idle_s,
      data_s,
      stop_s
   } rx_state_t;

   typedef logic [uart_cfg_pkg::TICK_CNT_W-1:0] tick_cnt_t;
   typedef logic [uart_cfg_pkg::BIT_CNT_W-1:0]  bit_cnt_t;

   rx_state_t                  state;
   rx_state_t                  state_n;
   tick_cnt_t                  tick_cnt;
   tick_cnt_t                  tick_cnt_n;
   bit_cnt_t                   bit_cnt;
   bit_cnt_t                   bit_cnt_n;
   uart_types_pkg::uart_byte_t shreg;
   uart_types_pkg::uart_byte_t shreg_n;
   uart_types_pkg::rx_frame_t  frame_n;
   logic                       done_n;
   logic                       half_hit;
   logic                       bit_end;

   assign half_hit = (tick_cnt == tick_cnt_t'(uart_cfg_pkg::HALF_BIT - 1));
   assign bit_end  = (tick_cnt == tick_cnt_t'(uart_cfg_pkg::OVERSAMPLE - 1));

   // ----------------------------------------------------------
   // next state
   // ----------------------------------------------------------

   always_comb begin
      state_n    = state;
      tick_cnt_n = tick_cnt;
      bit_cnt_n  = bit_cnt;
      shreg_n    = shreg;
      frame_n    = frame_o;
      done_n     = 1'b0;
      if (rx_en_i && tick_i) begin
         case (state)
            idle_s: begin
               if (rx_i) begin
                  tick_cnt_n = '0;  // a short glitch does not count as a start.
               end else if (half_hit) begin
                  state_n    = data_s;
                  tick_cnt_n = '0;
               end else begin
                  tick_cnt_n = tick_cnt + 1'b1;
               end
            end
            data_s: begin
               if (bit_end) begin
                  shreg_n    = {rx_i, shreg[uart_cfg_pkg::DATA_BITS-1:1]};
                  tick_cnt_n = '0;
                  bit_cnt_n  = bit_cnt + 1'b1;
                  if (bit_cnt == bit_cnt_t'(uart_cfg_pkg::DATA_BITS - 1)) begin
                     state_n   = stop_s;
                     bit_cnt_n = '0;
                  end
               end else begin
                  tick_cnt_n = tick_cnt + 1'b1;
               end
            end
            stop_s: begin
               if (bit_end) begin
                  frame_n.data      = shreg;
                  frame_n.frame_err = ~rx_i;
                  done_n            = 1'b1;
                  state_n           = idle_s;
                  tick_cnt_n        = '0;
               end else begin
                  tick_cnt_n = tick_cnt + 1'b1;
               end
            end
            default: begin
               state_n = idle_s;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state    <= idle_s;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         done_o   <= 1'b0;
      end else begin
         state    <= state_n;
         tick_cnt <= tick_cnt_n;
         bit_cnt  <= bit_cnt_n;
         done_o   <= done_n;
      end
      shreg   <= shreg_n;
      frame_o <= frame_n;
   end

   done_pulse_a: assert property (
      @(posedge clk_i) disable iff (!rst_i) done_o |=> !done_o
   );

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       tick_i,
   input  logic                       req_i,
   input  uart_types_pkg::uart_byte_t data_i,
   output logic                       pop_o,
   output logic                       tx_o
);

   typedef enum logic [1:0] {
      idle_s,
      start_s,
      data_s,
      stop_s
   } tx_state_t;

   typedef logic [uart_cfg_pkg::TICK_CNT_W-1:0] tick_cnt_t;
   typedef logic [uart_cfg_pkg::BIT_CNT_W-1:0]  bit_cnt_t;

   tx_state_t                  state;
   tx_state_t                  state_n;
   tick_cnt_t                  tick_cnt;
   tick_cnt_t                  tick_cnt_n;
   bit_cnt_t                   bit_cnt;
   bit_cnt_t                   bit_cnt_n;
   uart_types_pkg::uart_byte_t shreg;
   uart_types_pkg::uart_byte_t shreg_n;
   logic                       tx_n;
   logic                       bit_end;

   assign bit_end = tick_i && (tick_cnt == tick_cnt_t'(uart_cfg_pkg::OVERSAMPLE - 1));

   // a new byte is taken from idle or straight at the end of a stop bit.
   assign pop_o = tick_i && req_i && ((state == idle_s) || ((state == stop_s) && bit_end));

   always_comb begin
      state_n    = state;
      tick_cnt_n = tick_cnt;
      bit_cnt_n  = bit_cnt;
      shreg_n    = shreg;
      if (pop_o) begin
         state_n    = start_s;
         tick_cnt_n = '0;
         bit_cnt_n  = '0;
         shreg_n    = data_i;
      end else if (tick_i && (state != idle_s)) begin
         tick_cnt_n = tick_cnt + 1'b1;
         if (bit_end) begin
            tick_cnt_n = '0;
            case (state)
               start_s: state_n = data_s;
               data_s: begin
                  shreg_n = shreg >> 1;  // next data bit moves to the lsb.
                  if (bit_cnt == bit_cnt_t'(uart_cfg_pkg::DATA_BITS - 1)) begin
                     state_n = stop_s;
                  end else begin
                     bit_cnt_n = bit_cnt + 1'b1;
                  end
               end
               default: state_n = idle_s;
            endcase
         end
      end
   end

   always_comb begin
      case (state_n)
         start_s: tx_n = 1'b0;
         data_s:  tx_n = shreg_n[0];
         default: tx_n = 1'b1;  // idle and stop hold the line high.
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state    <= idle_s;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         tx_o     <= 1'b1;
      end else begin
         state    <= state_n;
         tick_cnt <= tick_cnt_n;
         bit_cnt  <= bit_cnt_n;
         tx_o     <= tx_n;
      end
      shreg <= shreg_n;
   end

   idle_high_a: assert property (
      @(posedge clk_i) disable iff (!rst_i) (state == idle_s) |-> tx_o
   );

endmodule

// ==== design/uart_fifo.sv ====
`timescale 1ns/1ps

module uart_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 8
) (
   input  logic     clk_i,
   input  logic     rst_i,
   input  logic     push_i,
   input  payload_t data_i,
   input  logic     pop_i,
   output payload_t data_o,
   output logic     full_o,
   output logic     not_empty_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   // pointers wrap at DEPTH, which need not be a power of two.
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign do_push     = push_i && !full_o;
   assign do_pop      = pop_i && not_empty_o;
   assign full_o      = (count == CNT_W'(DEPTH));
   assign not_empty_o = (count != '0);
   assign data_o      = mem[rd_ptr];  // head is visible without a pop.

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= next_ptr(wr_ptr);
         if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
         count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      end
      if (do_push) mem[wr_ptr] <= data_i;
   end

   count_bound_a: assert property (
      @(posedge clk_i) disable iff (!rst_i) count <= CNT_W'(DEPTH)
   );

endmodule

// ==== design/uart_top.sv ====
`timescale 1ns/1ps

module uart_top (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       rx_i,
   input  logic                       rx_en_i,
   input  uart_types_pkg::uart_byte_t tx_data_i,
   input  logic                       tx_push_i,
   input  logic                       rx_pop_i,
   output logic                       tx_o,
   output logic                       tx_full_o,
   output uart_types_pkg::rx_frame_t  rx_frame_o,
   output logic                       rx_valid_o
);

   logic                       tick;
   logic                       rx_done;
   uart_types_pkg::rx_frame_t  rx_frame;
   logic                       tx_req;
   logic                       tx_pop;
   uart_types_pkg::uart_byte_t tx_byte;

   // ----------------------------------------------------------
   // timing and receive path
   // ----------------------------------------------------------

   uart_baud_gen uart_baud_gen_inst (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .tick_o (tick)
   );

   uart_rx uart_rx_inst (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .tick_i  (tick),
      .rx_i    (rx_i),
      .rx_en_i (rx_en_i),
      .frame_o (rx_frame),
      .done_o  (rx_done)
   );

   // frames arriving while full are dropped by the FIFO itself.
   uart_fifo #(
      .payload_t (uart_types_pkg::rx_frame_t),
      .DEPTH     (uart_cfg_pkg::FIFO_DEPTH)
   ) rx_fifo_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .push_i      (rx_done),
      .data_i      (rx_frame),
      .pop_i       (rx_pop_i),
      .data_o      (rx_frame_o),
      .full_o      (),
      .not_empty_o (rx_valid_o)
   );

   // ----------------------------------------------------------
   // transmit path
   // ----------------------------------------------------------

   uart_fifo #(
      .payload_t (uart_types_pkg::uart_byte_t),
      .DEPTH     (uart_cfg_pkg::FIFO_DEPTH)
   ) tx_fifo_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .push_i      (tx_push_i),
      .data_i      (tx_data_i),
      .pop_i       (tx_pop),
      .data_o      (tx_byte),
      .full_o      (tx_full_o),
      .not_empty_o (tx_req)
   );

   uart_tx uart_tx_inst (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .tick_i (tick),
      .req_i  (tx_req),
      .data_i (tx_byte),
      .pop_o  (tx_pop),
      .tx_o   (tx_o)
   );

endmodule

// ==== dv/uart_tb.sv ====
`timescale 1ns/1ps

module uart_tb;

   localparam int BIT_CYCLES   = uart_cfg_pkg::OVERSAMPLE * uart_cfg_pkg::CLKS_PER_TICK;
   localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
   localparam int N_RAND       = 20;
   localparam int N_TX         = 12;
   localparam int TOTAL_FRAMES = 1 + N_RAND + 1 + 2 + N_TX;
   localparam int LIMIT_CYCLES = TOTAL_FRAMES * FRAME_CYCLES + 8000;

   logic                       clk_i;
   logic                       rst_i;
   logic                       rx_line;
   logic                       rx_en;
   uart_types_pkg::uart_byte_t tx_data;
   logic                       tx_push;
   logic                       rx_pop;
   logic                       tx_line;
   logic                       tx_full;
   uart_types_pkg::rx_frame_t  rx_frame;
   logic                       rx_valid;

   uart_types_pkg::rx_frame_t  exp_q[$];
   uart_types_pkg::uart_byte_t tx_sent[$];
   uart_types_pkg::uart_byte_t tx_seen[$];
   logic [31:0]                rng_state = 32'd78185;
   int                         err_count  = 0;
   int                         pass_count = 0;
   int                         fail_count = 0;

   uart_top uart_top_inst (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .rx_i       (rx_line),
      .rx_en_i    (rx_en),
      .tx_data_i  (tx_data),
      .tx_push_i  (tx_push),
      .rx_pop_i   (rx_pop),
      .tx_o       (tx_line),
      .tx_full_o  (tx_full),
      .rx_frame_o (rx_frame),
      .rx_valid_o (rx_valid)
   );

   initial clk_i = 1'b0;
   always #4 clk_i = ~clk_i;

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // the frame a correct receiver reports for one byte and stop level.
   function automatic uart_types_pkg::rx_frame_t expected_frame(
      input uart_types_pkg::uart_byte_t b,
      input logic                       stop_level
   );
      uart_types_pkg::rx_frame_t f;
      f.data      = b;
      f.frame_err = ~stop_level;
      return f;
   endfunction

   task automatic send_frame(input uart_types_pkg::uart_byte_t b, input logic stop_low);
      @(posedge clk_i);
      rx_line <= 1'b0;
      repeat (BIT_CYCLES) @(posedge clk_i);
      for (int i = 0; i < uart_cfg_pkg::DATA_BITS; i++) begin
         rx_line <= b[i];  // lsb goes out first.
         repeat (BIT_CYCLES) @(posedge clk_i);
      end
      if (stop_low) begin
         rx_line <= 1'b0;
         repeat (BIT_CYCLES * 3 / 4) @(posedge clk_i);
         rx_line <= 1'b1;  // released after the stop sample so no new start is seen.
         repeat (BIT_CYCLES / 4 - 1) @(posedge clk_i);
      end else begin
         rx_line <= 1'b1;
         repeat (BIT_CYCLES - 1) @(posedge clk_i);  // the next frame adds the last cycle.
      end
   endtask

   task automatic push_tx_byte(input uart_types_pkg::uart_byte_t b);
      @(negedge clk_i);
      while (tx_full) @(negedge clk_i);
      @(posedge clk_i);
      tx_data <= b;
      tx_push <= 1'b1;
      @(posedge clk_i);
      tx_push <= 1'b0;
   endtask

   task automatic drain_rx();
      while (exp_q.size() != 0) @(negedge clk_i);
   endtask

   task automatic finish_test(input string name, input int errs_before);
      if (err_count == errs_before) begin
         pass_count++;
         $display("test %s: pass", name);
      end else begin
         fail_count++;
         $display("test %s: fail with %0d errors", name, err_count - errs_before);
      end
   endtask

   // ------------------------------------------------------------
   // receive side compare, with pops at random times
   // ------------------------------------------------------------

   initial begin : rx_compare
      int unsigned               delay;
      uart_types_pkg::rx_frame_t want;
      rx_pop = 1'b0;
      wait (rst_i === 1'b1);
      forever begin
         @(negedge clk_i);
         if (rx_valid === 1'b1) begin
            delay = next_random() % 512;  // shorter than one frame, so few frames pile up.
            repeat (delay) @(negedge clk_i);
            if (exp_q.size() == 0) begin
               $display("%0t ns: frame 0x%03h appeared on rx_frame_o with none expected",
                        $time, rx_frame);
               err_count++;
            end else begin
               want = exp_q[0];
               if (rx_frame !== want) begin
                  $display("Mismatch at %0t ns: rx_frame_o expected 0x%03h got 0x%03h",
                           $time, want, rx_frame);
                  err_count++;
               end
            end
            @(posedge clk_i);
            rx_pop <= 1'b1;
            @(posedge clk_i);
            rx_pop <= 1'b0;
            if (exp_q.size() != 0) void'(exp_q.pop_front());
         end
      end
   end

   // decodes tx_o at bit middles.
   initial begin : tx_monitor
      uart_types_pkg::uart_byte_t b;
      wait (rst_i === 1'b1);
      forever begin
         @(negedge clk_i);
         if (tx_line === 1'b0) begin
            repeat (BIT_CYCLES / 2) @(negedge clk_i);
            if (tx_line !== 1'b0) begin
               $display("Mismatch at %0t ns: tx_o start bit expected 0 got %b",
                        $time, tx_line);
               err_count++;
            end
            for (int i = 0; i < uart_cfg_pkg::DATA_BITS; i++) begin
               repeat (BIT_CYCLES) @(negedge clk_i);
               b[i] = tx_line;
            end
            repeat (BIT_CYCLES) @(negedge clk_i);
            if (tx_line !== 1'b1) begin
               $display("Mismatch at %0t ns: tx_o stop bit expected 1 got %b",
                        $time, tx_line);
               err_count++;
            end
            tx_seen.push_back(b);
         end
      end
   end

   initial begin : watchdog
      repeat (LIMIT_CYCLES) @(posedge clk_i);
      $display("run timed out after %0d cycles", LIMIT_CYCLES);
      $display("Regression failed");
      $finish;
   end

   // ------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------

   initial begin : stimulus
      int                         errs;
      uart_types_pkg::uart_byte_t b;
      rst_i   = 1'b0;
      rx_line = 1'b1;
      rx_en   = 1'b0;
      tx_data = '0;
      tx_push = 1'b0;
      repeat (4) @(posedge clk_i);
      rst_i <= 1'b1;
      rx_en <= 1'b1;

      errs = err_count;
      @(negedge clk_i);
      if (tx_line !== 1'b1) begin
         $display("Mismatch at %0t ns: tx_o expected 1 got %b", $time, tx_line);
         err_count++;
      end
      if (rx_valid !== 1'b0) begin
         $display("Mismatch at %0t ns: rx_valid_o expected 0 got %b", $time, rx_valid);
         err_count++;
      end
      if (tx_full !== 1'b0) begin
         $display("Mismatch at %0t ns: tx_full_o expected 0 got %b", $time, tx_full);
         err_count++;
      end
      finish_test("reset_state", errs);

      errs = err_count;
      b = 8'hA5;
      exp_q.push_back(expected_frame(b, 1'b1));
      send_frame(b, 1'b0);
      drain_rx();
      finish_test("single_byte", errs);

      errs = err_count;
      for (int n = 0; n < N_RAND; n++) begin
         b = uart_types_pkg::uart_byte_t'(next_random());
         exp_q.push_back(expected_frame(b, 1'b1));
         send_frame(b, 1'b0);
      end
      drain_rx();
      finish_test("random_stream", errs);

      errs = err_count;
      b = 8'h3C;
      exp_q.push_back(expected_frame(b, 1'b0));
      send_frame(b, 1'b1);
      drain_rx();
      finish_test("framing_error", errs);

      errs = err_count;
      @(posedge clk_i);
      rx_en <= 1'b0;
      send_frame(8'h81, 1'b0);
      @(negedge clk_i);
      if (rx_valid !== 1'b0) begin
         $display("Mismatch at %0t ns: rx_valid_o expected 0 got %b", $time, rx_valid);
         err_count++;
      end
      @(posedge clk_i);
      rx_en <= 1'b1;
      b = 8'h5E;
      exp_q.push_back(expected_frame(b, 1'b1));
      send_frame(b, 1'b0);
      drain_rx();
      finish_test("rx_disabled", errs);

      errs = err_count;
      for (int n = 0; n < N_TX; n++) begin
         b = uart_types_pkg::uart_byte_t'(next_random());
         push_tx_byte(b);
         tx_sent.push_back(b);
      end
      while (tx_seen.size() < tx_sent.size()) @(negedge clk_i);
      repeat (BIT_CYCLES) @(negedge clk_i);
      if (tx_line !== 1'b1) begin
         $display("Mismatch at %0t ns: tx_o expected 1 got %b", $time, tx_line);
         err_count++;
      end
      for (int n = 0; n < N_TX; n++) begin
         if (tx_seen[n] !== tx_sent[n]) begin
            $display("Mismatch at %0t ns: tx_o byte %0d expected 0x%02h got 0x%02h",
                     $time, n, tx_sent[n], tx_seen[n]);
            err_count++;
         end
      end
      finish_test("tx_stream", errs);

      $display("tests passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0 && err_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// ==== all.f ====
design/uart_cfg_pkg.sv
design/uart_types_pkg.sv
design/uart_baud_gen.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_fifo.sv
design/uart_top.sv
dv/uart_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= uart_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# the run passes only when the log holds the pass line.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
